//--- logic/ms7200_cfg_pkg.sv
package ms7200_cfg_pkg;

    typedef logic [15:0] reg_addr_t;
    typedef logic [7:0]  reg_data_t;
    typedef logic [5:0]  cmd_index_t;
    typedef logic [31:0] freq_word_t;

    // write = 1 for a register write, 0 for a read
    typedef struct packed {
        logic      write;
        reg_addr_t addr;
        reg_data_t data;
    } cfg_entry_t;

    typedef enum logic [1:0] {
        SEQ_CONNECT,
        SEQ_INIT,
        SEQ_POLL,
        SEQ_RESTART
    } seq_state_t;

    localparam reg_data_t DEVICE_ID       = 8'h56;
    localparam reg_data_t CONNECT_KEY     = 8'h5A;
    localparam reg_addr_t FREQ_ADDR_FIRST = 16'h209C;

    localparam cmd_index_t CONNECT_FIRST = 6'd0;
    localparam cmd_index_t CONNECT_LAST  = 6'd1;
    localparam cmd_index_t INIT_FIRST    = 6'd2;
    localparam cmd_index_t INIT_LAST     = 6'd37;
    localparam cmd_index_t POLL_FIRST    = 6'd38;
    localparam cmd_index_t POLL_LAST     = 6'd41;
    localparam cmd_index_t RESTART_FIRST = 6'd42;
    localparam cmd_index_t RESTART_LAST  = 6'd48;

    localparam int CFG_DEPTH = 49;

    localparam cfg_entry_t CFG_TABLE [CFG_DEPTH] = '{
        // connect check
        '{1'b1, 16'h0003, 8'h5A}, '{1'b0, 16'h0003, 8'h00},
        // core init
        '{1'b1, 16'h0204, 8'h02}, '{1'b1, 16'h0205, 8'h40}, '{1'b1, 16'h0004, 8'h01},
        '{1'b1, 16'h0009, 8'h26}, '{1'b1, 16'h102E, 8'h01}, '{1'b1, 16'h1025, 8'hB0},
        '{1'b1, 16'h102D, 8'h83}, '{1'b1, 16'h1000, 8'h20}, '{1'b1, 16'h100F, 8'h04},
        '{1'b1, 16'h0003, 8'hC3}, '{1'b1, 16'h103B, 8'h02}, '{1'b1, 16'h00E1, 8'h00},
        '{1'b1, 16'h00A8, 8'h08}, '{1'b1, 16'h000A, 8'h00}, '{1'b1, 16'h0016, 8'h02},
        '{1'b1, 16'h00E2, 8'h01}, '{1'b1, 16'h00C2, 8'h14}, '{1'b1, 16'h102D, 8'hC7},
        '{1'b1, 16'h1005, 8'h04}, '{1'b1, 16'h1003, 8'h14}, '{1'b1, 16'h1004, 8'h01},
        '{1'b1, 16'h1000, 8'h60}, '{1'b1, 16'h1020, 8'h13}, '{1'b1, 16'h1021, 8'h04},
        '{1'b1, 16'h1022, 8'h04}, '{1'b1, 16'h1023, 8'h0C}, '{1'b1, 16'h102B, 8'h33},
        '{1'b1, 16'h102C, 8'h33}, '{1'b1, 16'h00F0, 8'h10}, '{1'b1, 16'h000C, 8'h80},
        '{1'b1, 16'h000C, 8'h00}, '{1'b1, 16'h000A, 8'h04}, '{1'b1, 16'h2000, 8'h0F},
        '{1'b1, 16'h2001, 8'h00}, '{1'b1, 16'h2002, 8'h00}, '{1'b1, 16'h2003, 8'h01},
        // input frequency status
        '{1'b0, 16'h209C, 8'h00}, '{1'b0, 16'h209D, 8'h00},
        '{1'b0, 16'h209E, 8'h00}, '{1'b0, 16'h209F, 8'h00},
        // restart after lock
        '{1'b1, 16'h1010, 8'h01}, '{1'b1, 16'h1024, 8'h00}, '{1'b1, 16'h0200, 8'h00},
        '{1'b1, 16'h1024, 8'h70}, '{1'b1, 16'h0200, 8'h07}, '{1'b1, 16'h0215, 8'h01},
        '{1'b1, 16'h0215, 8'h00}
    };

endpackage

//--- logic/iic_cmd_if.sv
`timescale 1ns/1ps

// one expanded command, table stage to issue stage
interface iic_cmd_if;

    logic                      valid;
    logic                      write;
    ms7200_cfg_pkg::reg_addr_t addr;
    ms7200_cfg_pkg::reg_data_t data;

    modport tbl (
        output valid,
        output write,
        output addr,
        output data
    );

    modport issue (
        input valid,
        input write,
        input addr,
        input data
    );

endinterface

//--- logic/iic_rsp_if.sv
`timescale 1ns/1ps

// completed transaction, each valid also hands back one credit
interface iic_rsp_if;

    logic                      valid;
    logic                      write;
    ms7200_cfg_pkg::reg_addr_t addr;
    ms7200_cfg_pkg::reg_data_t data;

    modport issue (
        output valid,
        output write,
        output addr,
        output data
    );

    modport sink (
        input valid,
        input write,
        input addr,
        input data
    );

endinterface

//--- logic/ms7200_sequencer.sv
`timescale 1ns/1ps

module ms7200_sequencer #(
    parameter int CMD_CREDITS = 2
) (
    input  logic                       clk,
    input  logic                       rstn,
    iic_rsp_if.sink                    rsp,
    input  logic                       poll_done,
    input  logic                       freq_locked,
    output logic                       idx_valid,
    output ms7200_cfg_pkg::cmd_index_t idx,
    output logic                       lock_clear,
    output logic                       init_over
);

    localparam int CW = $clog2(CMD_CREDITS + 1);

    ms7200_cfg_pkg::seq_state_t state;
    ms7200_cfg_pkg::seq_state_t start_state;
    ms7200_cfg_pkg::cmd_index_t next_idx;
    ms7200_cfg_pkg::cmd_index_t last_idx;
    ms7200_cfg_pkg::cmd_index_t rsp_idx;
    logic [CW-1:0]              credits;
    logic                       issuing;
    logic                       send;
    logic                       phase_done;
    logic                       start;

    function automatic ms7200_cfg_pkg::cmd_index_t phase_first(ms7200_cfg_pkg::seq_state_t s);
        case (s)
            ms7200_cfg_pkg::SEQ_INIT:    return ms7200_cfg_pkg::INIT_FIRST;
            ms7200_cfg_pkg::SEQ_POLL:    return ms7200_cfg_pkg::POLL_FIRST;
            ms7200_cfg_pkg::SEQ_RESTART: return ms7200_cfg_pkg::RESTART_FIRST;
            default:                     return ms7200_cfg_pkg::CONNECT_FIRST;
        endcase
    endfunction

    function automatic ms7200_cfg_pkg::cmd_index_t phase_last(ms7200_cfg_pkg::seq_state_t s);
        case (s)
            ms7200_cfg_pkg::SEQ_INIT:    return ms7200_cfg_pkg::INIT_LAST;
            ms7200_cfg_pkg::SEQ_POLL:    return ms7200_cfg_pkg::POLL_LAST;
            ms7200_cfg_pkg::SEQ_RESTART: return ms7200_cfg_pkg::RESTART_LAST;
            default:                     return ms7200_cfg_pkg::CONNECT_LAST;
        endcase
    endfunction

    assign send       = issuing && (credits != '0);
    assign phase_done = rsp.valid && (rsp_idx == last_idx);

    // =========================================================================
    // phase transitions
    // =========================================================================
    always_comb begin
        start       = 1'b0;
        start_state = state;
        case (state)
            ms7200_cfg_pkg::SEQ_CONNECT: begin
                if (phase_done) begin
                    start = 1'b1;
                    // retry until the read-back matches
                    if (rsp.data == ms7200_cfg_pkg::CONNECT_KEY) begin
                        start_state = ms7200_cfg_pkg::SEQ_INIT;
                    end
                end
            end
            ms7200_cfg_pkg::SEQ_INIT: begin
                if (phase_done) begin
                    start       = 1'b1;
                    start_state = ms7200_cfg_pkg::SEQ_POLL;
                end
            end
            ms7200_cfg_pkg::SEQ_POLL: begin
                if (poll_done) begin
                    start = 1'b1;
                    if (freq_locked) begin
                        start_state = ms7200_cfg_pkg::SEQ_RESTART;
                    end
                end
            end
            default: begin
                if (phase_done) begin
                    start       = 1'b1;
                    start_state = ms7200_cfg_pkg::SEQ_POLL;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state      <= ms7200_cfg_pkg::SEQ_CONNECT;
            next_idx   <= ms7200_cfg_pkg::CONNECT_FIRST;
            last_idx   <= ms7200_cfg_pkg::CONNECT_LAST;
            rsp_idx    <= ms7200_cfg_pkg::CONNECT_FIRST;
            issuing    <= 1'b1;
            credits    <= CW'(CMD_CREDITS);
            idx_valid  <= 1'b0;
            lock_clear <= 1'b0;
            init_over  <= 1'b0;
        end else begin
            idx_valid  <= send;
            credits    <= credits - CW'(send) + CW'(rsp.valid);
            lock_clear <= (state == ms7200_cfg_pkg::SEQ_POLL) && poll_done && freq_locked;
            if (send) begin
                if (next_idx == last_idx) begin
                    issuing <= 1'b0;
                end else begin
                    next_idx <= next_idx + 1'b1;
                end
            end
            if (rsp.valid) begin
                rsp_idx <= rsp_idx + 1'b1;
            end
            // all credits are home when a phase starts
            if (start) begin
                state    <= start_state;
                next_idx <= phase_first(start_state);
                last_idx <= phase_last(start_state);
                rsp_idx  <= phase_first(start_state);
                issuing  <= 1'b1;
            end
            if (state == ms7200_cfg_pkg::SEQ_RESTART && phase_done) begin
                init_over <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            idx <= next_idx;
        end
    end

endmodule

//--- logic/ms7200_cmd_table.sv
`timescale 1ns/1ps

module ms7200_cmd_table (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       idx_valid,
    input  ms7200_cfg_pkg::cmd_index_t idx,
    iic_cmd_if.tbl                     cmd
);

    ms7200_cfg_pkg::cfg_entry_t entry;
    ms7200_cfg_pkg::cfg_entry_t lookup;

    // indices past the table fall back to a harmless status read
    always_comb begin
        if (idx <= ms7200_cfg_pkg::RESTART_LAST) begin
            lookup = ms7200_cfg_pkg::CFG_TABLE[idx];
        end else begin
            lookup = ms7200_cfg_pkg::CFG_TABLE[ms7200_cfg_pkg::POLL_FIRST];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cmd.valid <= 1'b0;
        end else begin
            cmd.valid <= idx_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (idx_valid) begin
            entry <= lookup;
        end
    end

    assign cmd.write = entry.write;
    assign cmd.addr  = entry.addr;
    assign cmd.data  = entry.data;

endmodule

//--- logic/iic_issue.sv
`timescale 1ns/1ps

module iic_issue #(
    parameter int CMD_CREDITS = 2
) (
    input  logic                      clk,
    input  logic                      rstn,
    iic_cmd_if.issue                  cmd,
    input  logic                      busy,
    input  ms7200_cfg_pkg::reg_data_t data_out,
    iic_rsp_if.issue                  rsp,
    output logic                      iic_trig,
    output logic                      w_r,
    output ms7200_cfg_pkg::reg_addr_t addr,
    output ms7200_cfg_pkg::reg_data_t data_in
);

    localparam int PW = (CMD_CREDITS > 1) ? $clog2(CMD_CREDITS) : 1;
    localparam int CW = $clog2(CMD_CREDITS + 1);

    typedef enum logic [1:0] {
        ISS_IDLE,
        ISS_TRIG,
        ISS_BUSY
    } iss_state_t;

    ms7200_cfg_pkg::cfg_entry_t fifo_mem [CMD_CREDITS];
    logic [PW-1:0]              wr_ptr;
    logic [PW-1:0]              rd_ptr;
    logic [CW-1:0]              fill;
    iss_state_t                 state;
    logic                       busy_d;
    logic                       busy_fall;
    logic                       push;
    logic                       pop;
    logic                       done;

    function automatic logic [PW-1:0] ptr_next(logic [PW-1:0] p);
        if (p == PW'(CMD_CREDITS - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // credits upstream keep the fifo from overflowing
    assign push      = cmd.valid;
    assign pop       = (state == ISS_IDLE) && (fill != '0) && !busy;
    assign busy_fall = busy_d && !busy;
    assign done      = (state == ISS_BUSY) && busy_fall;

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= {cmd.write, cmd.addr, cmd.data};
        end
    end

    // =========================================================================
    // fifo pointers and transaction fsm
    // =========================================================================
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            fill      <= '0;
            state     <= ISS_IDLE;
            busy_d    <= 1'b0;
            iic_trig  <= 1'b0;
            rsp.valid <= 1'b0;
        end else begin
            busy_d    <= busy;
            iic_trig  <= pop;
            rsp.valid <= done;
            fill      <= fill + CW'(push) - CW'(pop);
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case (state)
                ISS_IDLE: begin
                    if (pop) begin
                        state <= ISS_TRIG;
                    end
                end
                // wait for the master to pick up the trig
                ISS_TRIG: begin
                    if (busy) begin
                        state <= ISS_BUSY;
                    end
                end
                ISS_BUSY: begin
                    if (busy_fall) begin
                        state <= ISS_IDLE;
                    end
                end
                default: state <= ISS_IDLE;
            endcase
        end
    end

    // held from trig until busy falls
    always_ff @(posedge clk) begin
        if (pop) begin
            w_r     <= fifo_mem[rd_ptr].write;
            addr    <= fifo_mem[rd_ptr].addr;
            data_in <= fifo_mem[rd_ptr].data;
        end
        if (done) begin
            rsp.write <= w_r;
            rsp.addr  <= addr;
            rsp.data  <= data_out;
        end
    end

endmodule

//--- logic/freq_lock_detect.sv
`timescale 1ns/1ps

module freq_lock_detect (
    input  logic    clk,
    input  logic    rstn,
    iic_rsp_if.sink rsp,
    input  logic    lock_clear,
    output logic    poll_done,
    output logic    freq_locked
);

    ms7200_cfg_pkg::reg_addr_t  offset;
    ms7200_cfg_pkg::freq_word_t new_word;
    ms7200_cfg_pkg::freq_word_t prev_word;
    logic [23:0]                low_bytes;
    logic                       prev_valid;
    logic                       freq_rd;
    logic                       word_done;

    assign offset    = rsp.addr - ms7200_cfg_pkg::FREQ_ADDR_FIRST;
    assign freq_rd   = rsp.valid && !rsp.write && (offset < 16'd4);
    assign word_done = freq_rd && (offset[1:0] == 2'd3);
    // top byte arrives last
    assign new_word  = {rsp.data, low_bytes};

    always_ff @(posedge clk) begin
        if (freq_rd && !word_done) begin
            low_bytes[{offset[1:0], 3'b000} +: 8] <= rsp.data;
        end
        if (word_done) begin
            prev_word <= new_word;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            poll_done   <= 1'b0;
            freq_locked <= 1'b0;
            prev_valid  <= 1'b0;
        end else begin
            poll_done <= word_done;
            if (lock_clear) begin
                freq_locked <= 1'b0;
                prev_valid  <= 1'b0;
            end else if (word_done) begin
                prev_valid <= 1'b1;
                // lock shows as 00 then 10 in bits 17:16
                if (prev_valid && prev_word[17:16] == 2'b00 && new_word[17:16] == 2'b10) begin
                    freq_locked <= 1'b1;
                end
            end
        end
    end

endmodule

//--- logic/ms7200_ctrl.sv
`timescale 1ns/1ps

module ms7200_ctrl #(
    parameter int CMD_CREDITS = 2
) (
    input  logic                      clk,
    input  logic                      rstn,
    output logic                      init_over,
    output ms7200_cfg_pkg::reg_data_t device_id,
    output logic                      iic_trig,
    output logic                      w_r,
    output ms7200_cfg_pkg::reg_addr_t addr,
    output ms7200_cfg_pkg::reg_data_t data_in,
    input  logic                      busy,
    input  ms7200_cfg_pkg::reg_data_t data_out
);

    logic                       idx_valid;
    ms7200_cfg_pkg::cmd_index_t idx;
    logic                       lock_clear;
    logic                       poll_done;
    logic                       freq_locked;

    iic_cmd_if cmd_bus ();
    iic_rsp_if rsp_bus ();

    assign device_id = ms7200_cfg_pkg::DEVICE_ID;

    // =========================================================================
    // sequencer -> table -> issue, responses fed back
    // =========================================================================
    ms7200_sequencer #(
        .CMD_CREDITS (CMD_CREDITS)
    ) i_sequencer (
        .clk         (clk),
        .rstn        (rstn),
        .rsp         (rsp_bus.sink),
        .poll_done   (poll_done),
        .freq_locked (freq_locked),
        .idx_valid   (idx_valid),
        .idx         (idx),
        .lock_clear  (lock_clear),
        .init_over   (init_over)
    );

    ms7200_cmd_table i_cmd_table (
        .clk       (clk),
        .rstn      (rstn),
        .idx_valid (idx_valid),
        .idx       (idx),
        .cmd       (cmd_bus.tbl)
    );

    iic_issue #(
        .CMD_CREDITS (CMD_CREDITS)
    ) i_issue (
        .clk      (clk),
        .rstn     (rstn),
        .cmd      (cmd_bus.issue),
        .busy     (busy),
        .data_out (data_out),
        .rsp      (rsp_bus.issue),
        .iic_trig (iic_trig),
        .w_r      (w_r),
        .addr     (addr),
        .data_in  (data_in)
    );

    freq_lock_detect i_lock_detect (
        .clk         (clk),
        .rstn        (rstn),
        .rsp         (rsp_bus.sink),
        .lock_clear  (lock_clear),
        .poll_done   (poll_done),
        .freq_locked (freq_locked)
    );

endmodule

//--- testbench/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

//--- testbench/iic_master_model.sv
`timescale 1ns/1ps

module iic_master_model (
    input  logic                      clk,
    input  logic                      iic_trig,
    input  logic                      w_r,
    input  ms7200_cfg_pkg::reg_addr_t addr,
    output logic                      busy,
    output ms7200_cfg_pkg::reg_data_t data_out
);

    logic [31:0] seed;
    logic [31:0] freq_word;
    int          busy_left;
    int          key_reads;
    int          word_count;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // bits 17:16 per polled word, only words 4 and 5 give 00 then 10
    function automatic logic [1:0] scripted_bits(input int n);
        case (n)
            2:       return 2'b01;
            4:       return 2'b00;
            default: return 2'b10;
        endcase
    endfunction

    initial begin
        seed       = 32'ha9e7;
        freq_word  = '0;
        busy       = 1'b0;
        data_out   = '0;
        busy_left  = 0;
        key_reads  = 0;
        word_count = 0;
    end

    always @(negedge clk) begin
        if (busy_left != 0) begin
            busy_left = busy_left - 1;
            if (busy_left == 0) begin
                busy <= 1'b0;
            end
        end else if (iic_trig && !busy) begin
            seed      = lcg_next(seed);
            busy_left = 2 + int'(seed[18:16]);
            busy     <= 1'b1;
            if (!w_r && addr == 16'h0003) begin
                key_reads = key_reads + 1;
                // first two connect reads miss the key
                data_out <= (key_reads > 2) ? 8'h5A : 8'hA5 ^ 8'(key_reads);
            end else if (!w_r && addr >= 16'h209C && addr <= 16'h209F) begin
                if (addr == 16'h209C) begin
                    freq_word = {seed[31:18], scripted_bits(word_count), seed[15:0]};
                end
                data_out <= freq_word[8 * (addr - 16'h209C) +: 8];
                if (addr == 16'h209F) begin
                    word_count = word_count + 1;
                end
            end else begin
                data_out <= seed[31:24];
            end
        end
    end

endmodule

//--- testbench/ms7200_ctrl_chk.sv
`timescale 1ns/1ps

module ms7200_ctrl_chk (
    input logic                      clk,
    input logic                      rstn,
    input logic                      init_over,
    input ms7200_cfg_pkg::reg_data_t device_id,
    input logic                      iic_trig,
    input logic                      w_r,
    input ms7200_cfg_pkg::reg_addr_t addr,
    input ms7200_cfg_pkg::reg_data_t data_in,
    input logic                      busy,
    input ms7200_cfg_pkg::reg_data_t data_out
);

    ms7200_cfg_pkg::cfg_entry_t exp_cmd;
    ms7200_cfg_pkg::cfg_entry_t held;
    ms7200_cfg_pkg::freq_word_t freq_bytes;
    ms7200_cfg_pkg::freq_word_t new_word;
    ms7200_cfg_pkg::freq_word_t prev_word;
    int                         exp_idx;
    int                         error_count = 0;
    logic                       busy_d;
    logic                       fall;
    logic                       active;
    logic                       prev_ok;
    logic                       locked;
    logic                       over_pend;
    logic                       over_q;

    assign exp_cmd  = ms7200_cfg_pkg::CFG_TABLE[exp_idx];
    assign fall     = busy_d && !busy;
    assign new_word = {data_out, freq_bytes[23:0]};
    assign locked   = prev_ok && prev_word[17:16] == 2'b00 && new_word[17:16] == 2'b10;

    // ========================================================================
    // reference of the expected transaction order
    // ========================================================================
    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy_d    <= 1'b0;
            active    <= 1'b0;
            exp_idx   <= 0;
            prev_ok   <= 1'b0;
            over_pend <= 1'b0;
            over_q    <= 1'b0;
        end else begin
            busy_d <= busy;
            over_q <= over_pend;
            if (iic_trig) begin
                active <= 1'b1;
                held   <= {w_r, addr, data_in};
            end else if (fall) begin
                active <= 1'b0;
            end
            if (fall) begin
                exp_idx <= exp_idx + 1;
                if (exp_idx >= ms7200_cfg_pkg::POLL_FIRST &&
                        exp_idx <= ms7200_cfg_pkg::POLL_LAST) begin
                    freq_bytes[8 * (exp_idx - ms7200_cfg_pkg::POLL_FIRST) +: 8] <= data_out;
                end
                if (exp_idx == ms7200_cfg_pkg::CONNECT_LAST && data_out != 8'h5A) begin
                    exp_idx <= ms7200_cfg_pkg::CONNECT_FIRST;
                end
                // a lock forgets the previous word
                if (exp_idx == ms7200_cfg_pkg::POLL_LAST) begin
                    prev_word <= new_word;
                    prev_ok   <= !locked;
                    exp_idx   <= locked ? ms7200_cfg_pkg::RESTART_FIRST
                                        : ms7200_cfg_pkg::POLL_FIRST;
                end
                if (exp_idx == ms7200_cfg_pkg::RESTART_LAST) begin
                    exp_idx   <= ms7200_cfg_pkg::POLL_FIRST;
                    over_pend <= 1'b1;
                end
            end
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        (!rstn || $rose(rstn)) |=> !iic_trig && !init_over)
    else begin
        $error("Error iic_trig 0x%h init_over 0x%h expected 0x0 around reset",
               $sampled(iic_trig), $sampled(init_over));
        error_count++;
    end

    a_device_id: assert property (@(posedge clk) disable iff (!rstn)
        device_id == 8'h56)
    else begin
        $error("Error device_id 0x%h expected 0x56", $sampled(device_id));
        error_count++;
    end

    a_trig_idle: assert property (@(posedge clk) disable iff (!rstn)
        iic_trig |-> !$past(busy))
    else begin
        $error("trigger was issued while busy was still high");
        error_count++;
    end

    a_hold: assert property (@(posedge clk) disable iff (!rstn)
        active |-> {w_r, addr, data_in} == held)
    else begin
        $error("Error w_r/addr/data_in 0x%h expected 0x%h",
               $sampled({w_r, addr, data_in}), $sampled(held));
        error_count++;
    end

    a_cmd_write: assert property (@(posedge clk) disable iff (!rstn)
        iic_trig |-> w_r == exp_cmd.write)
    else begin
        $error("Error w_r 0x%h expected 0x%h", $sampled(w_r), $sampled(exp_cmd.write));
        error_count++;
    end

    a_cmd_addr: assert property (@(posedge clk) disable iff (!rstn)
        iic_trig |-> addr == exp_cmd.addr)
    else begin
        $error("Error addr 0x%h expected 0x%h", $sampled(addr), $sampled(exp_cmd.addr));
        error_count++;
    end

    a_cmd_data: assert property (@(posedge clk) disable iff (!rstn)
        iic_trig && w_r |-> data_in == exp_cmd.data)
    else begin
        $error("Error data_in 0x%h expected 0x%h", $sampled(data_in), $sampled(exp_cmd.data));
        error_count++;
    end

    a_init_over: assert property (@(posedge clk) disable iff (!rstn)
        init_over == over_q)
    else begin
        $error("Error init_over 0x%h expected 0x%h", $sampled(init_over), $sampled(over_q));
        error_count++;
    end

endmodule

bind ms7200_ctrl ms7200_ctrl_chk i_chk (
    .clk       (clk),
    .rstn      (rstn),
    .init_over (init_over),
    .device_id (device_id),
    .iic_trig  (iic_trig),
    .w_r       (w_r),
    .addr      (addr),
    .data_in   (data_in),
    .busy      (busy),
    .data_out  (data_out)
);

//--- testbench/tb_ms7200_ctrl.sv
`timescale 1ns/1ps

module tb_ms7200_ctrl;

    localparam int CMD_CREDITS = 2;
    localparam int CLK_NS      = 4;
    localparam int MAX_BUSY    = 9;
    localparam int TAIL_TXNS   = 8;
    // three connect tries, init, six polls up to lock, restart, tail polls
    localparam int TXN_COUNT   = 3 * 2 + 36 + 6 * 4 + 7 + TAIL_TXNS;
    localparam int WATCHDOG_NS = (TXN_COUNT * MAX_BUSY * 2 + 200) * CLK_NS;

    logic                      clk;
    logic                      rstn;
    logic                      busy;
    ms7200_cfg_pkg::reg_data_t data_out;
    logic                      init_over;
    ms7200_cfg_pkg::reg_data_t device_id;
    logic                      iic_trig;
    logic                      w_r;
    ms7200_cfg_pkg::reg_addr_t addr;
    ms7200_cfg_pkg::reg_data_t data_in;

    tb_clk_gen #(
        .PERIOD_NS (CLK_NS)
    ) i_clk_gen (
        .clk (clk)
    );

    ms7200_ctrl #(
        .CMD_CREDITS (CMD_CREDITS)
    ) i_ms7200_ctrl (
        .clk       (clk),
        .rstn      (rstn),
        .init_over (init_over),
        .device_id (device_id),
        .iic_trig  (iic_trig),
        .w_r       (w_r),
        .addr      (addr),
        .data_in   (data_in),
        .busy      (busy),
        .data_out  (data_out)
    );

    iic_master_model i_master (
        .clk      (clk),
        .iic_trig (iic_trig),
        .w_r      (w_r),
        .addr     (addr),
        .busy     (busy),
        .data_out (data_out)
    );

    task automatic fail_run(input string why);
        $display("SIMULATION FAILED");
        $fatal(1, "%s", why);
    endtask

    // ========================================================================
    // first assertion error ends the run
    // ========================================================================
    always @(i_ms7200_ctrl.i_chk.error_count) begin
        if (i_ms7200_ctrl.i_chk.error_count != 0) begin
            fail_run("an assertion in ms7200_ctrl_chk failed");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        fail_run("watchdog expired before lock, restart and the trailing polls");
    end

    initial begin
        rstn = 1'b0;
        repeat (8) @(negedge clk);
        rstn = 1'b1;
        // connect retries, init and polling up to the scripted lock
        @(posedge init_over);
        repeat (TAIL_TXNS) @(negedge busy);
        repeat (4) @(negedge clk);
        if (i_ms7200_ctrl.i_chk.error_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            fail_run("assertion errors were counted during the run");
        end
    end

endmodule

//--- flist.f
logic/ms7200_cfg_pkg.sv
logic/iic_cmd_if.sv
logic/iic_rsp_if.sv
logic/ms7200_sequencer.sv
logic/ms7200_cmd_table.sv
logic/iic_issue.sv
logic/freq_lock_detect.sv
logic/ms7200_ctrl.sv
testbench/tb_clk_gen.sv
testbench/iic_master_model.sv
testbench/ms7200_ctrl_chk.sv
testbench/tb_ms7200_ctrl.sv
